// ==== mipsCore.f ====
rtl/mipsPkg.sv
rtl/decoder.sv
rtl/regFile.sv
rtl/alu.sv
rtl/nextPc.sv
rtl/mipsCore.sv
verif/mipsCoreTb.sv

// ==== Makefile ====
# Verilator build and run of the mipsCore testbench

VERILATOR ?= verilator
TOP       ?= mipsCoreTb
FILELIST  ?= mipsCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/mipsCoreTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mipsCoreTb import mipsPkg::*; ();

	localparam logic [31:0] ResetPc = 32'h0000_3000;
	localparam int MaxCycles = 2000;

	logic        clk;
	logic        rst;
	logic [31:0] instr;
	logic        instrValid;
	logic [31:0] pc;
	logic        retValid;
	retire_t     retire;

	// Reference model state
	logic [31:0] modelRegs [32];
	logic [31:0] modelPc;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int seedDiscard;

	mipsCore #(.ResetPc(ResetPc)) mipsCore_inst (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instrValid (instrValid),
		.pc         (pc),
		.retValid   (retValid),
		.retire     (retire)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MaxCycles) begin
			$display("Timeout: the run did not finish within %0d cycles", MaxCycles);
			$display("Test FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Encoding and checking helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sa, input logic [5:0] fn);
		return {6'b000000, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	// ISA rules applied to the model, before the DUT takes the word
	task automatic predict(input logic [31:0] w, output logic we, output logic [4:0] dst,
		output logic [31:0] data, output logic [31:0] nxt);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sImm;
		logic [31:0] zImm;
		logic [31:0] pc4;
		logic        isBranch;
		logic        taken;
		a = modelRegs[w[25:21]];
		b = modelRegs[w[20:16]];
		sImm = {{16{w[15]}}, w[15:0]};
		zImm = {16'd0, w[15:0]};
		pc4 = modelPc + 32'd4;
		we = 1'b1;
		dst = w[20:16];
		data = 32'd0;
		nxt = pc4;
		isBranch = 1'b1;
		taken = 1'b0;
		case (w[31:26])
			opSpecial: begin
				isBranch = 1'b0;
				dst = w[15:11];
				case (w[5:0])
					fnAddu: data = a + b;
					fnSubu: data = a - b;
					fnAnd:  data = a & b;
					fnOr:   data = a | b;
					fnXor:  data = a ^ b;
					fnNor:  data = ~(a | b);
					fnSlt:  data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					fnSltu: data = (a < b) ? 32'd1 : 32'd0;
					fnSll:  data = b << w[10:6];
					fnSrl:  data = b >> w[10:6];
					fnSra:  data = (b >> w[10:6]) | (b[31] ? ~(32'hffff_ffff >> w[10:6]) : 32'd0);
					fnSllv: data = b << a[4:0];
					fnSrlv: data = b >> a[4:0];
					fnSrav: data = (b >> a[4:0]) | (b[31] ? ~(32'hffff_ffff >> a[4:0]) : 32'd0);
					fnJr: begin
						we = 1'b0;
						nxt = a;
					end
					default: we = 1'b0;
				endcase
			end
			opRegimm: begin
				we = 1'b0;
				if (w[20:16] == 5'd0) taken = a[31];
				else if (w[20:16] == 5'd1) taken = !a[31];
				else isBranch = 1'b0;
			end
			opBeq:  begin we = 1'b0; taken = (a == b); end
			opBne:  begin we = 1'b0; taken = (a != b); end
			opBlez: begin we = 1'b0; taken = a[31] || (a == 32'd0); end
			opBgtz: begin we = 1'b0; taken = !a[31] && (a != 32'd0); end
			opJ, opJal: begin
				isBranch = 1'b0;
				we = (w[31:26] == opJal);
				dst = 5'd31;
				data = pc4;
				nxt = {pc4[31:28], w[25:0], 2'b00};
			end
			opAddiu: begin isBranch = 1'b0; data = a + sImm; end
			opSlti:  begin isBranch = 1'b0; data = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0; end
			opSltiu: begin isBranch = 1'b0; data = (a < sImm) ? 32'd1 : 32'd0; end
			opAndi:  begin isBranch = 1'b0; data = a & zImm; end
			opOri:   begin isBranch = 1'b0; data = a | zImm; end
			opXori:  begin isBranch = 1'b0; data = a ^ zImm; end
			opLui:   begin isBranch = 1'b0; data = {w[15:0], 16'd0}; end
			default: begin
				isBranch = 1'b0;
				we = 1'b0;
			end
		endcase
		if (isBranch && taken) nxt = pc4 + {sImm[29:0], 2'b00};
		if (dst == 5'd0) we = 1'b0;
		if (we) modelRegs[dst] = data;
		modelPc = nxt;
	endtask

	// Offers one word, lets the DUT take it and checks the retire record
	task automatic execute(input logic [31:0] w);
		logic        we;
		logic [4:0]  dst;
		logic [31:0] data;
		logic [31:0] nxt;
		logic [31:0] oldPc;
		oldPc = modelPc;
		predict(w, we, dst, data, nxt);
		instr = w;
		instrValid = 1'b1;
		@(posedge clk);
		#2;
		instrValid = 1'b0;
		checkValue("retValid", {31'd0, retValid}, 32'd1);
		checkValue("retire.pc", retire.pc, oldPc);
		checkValue("retire.regWe", {31'd0, retire.regWe}, {31'd0, we});
		if (we) begin
			checkValue("retire.dstReg", {27'd0, retire.dstReg}, {27'd0, dst});
			checkValue("retire.wrData", retire.wrData, data);
		end
		checkValue("retire.nextPc", retire.nextPc, nxt);
		checkValue("pc", pc, nxt);
	endtask

	task automatic loadReg(input logic [4:0] r, input logic [31:0] value);
		execute(iType(opLui, 5'd0, r, value[31:16]));
		execute(iType(opOri, r, r, value[15:0]));
	endtask

	task automatic idleCycle();
		@(posedge clk);
		#2;
		checkValue("retValid", {31'd0, retValid}, 32'd0);
		checkValue("pc", pc, modelPc);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic resetState();
		checkValue("pc", pc, ResetPc);
		checkValue("retValid", {31'd0, retValid}, 32'd0);
		repeat (4) idleCycle();
	endtask

	task automatic registerAlu();
		logic [5:0] fns [8];
		fns = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu};
		loadReg(5'd1, $urandom | 32'h8000_0000);
		loadReg(5'd2, ($urandom & 32'h7fff_ffff) | 32'd1);
		loadReg(5'd3, $urandom);
		loadReg(5'd4, $urandom | 32'h8000_0000);
		foreach (fns[i]) begin
			execute(rType(5'd1, 5'd2, 5'd5, 5'd0, fns[i]));
			execute(rType(5'd3, 5'd4, 5'd6, 5'd0, fns[i]));
			execute(rType(5'd4, 5'd1, 5'd7, 5'd0, fns[i]));
		end
	endtask

	task automatic immediateAlu();
		logic [5:0] ops [6];
		ops = '{opAddiu, opSlti, opSltiu, opAndi, opOri, opXori};
		foreach (ops[i]) begin
			// Bit 15 set to tell sign from zero extension
			execute(iType(ops[i], 5'd1, 5'd8, 16'($urandom) | 16'h8000));
			execute(iType(ops[i], 5'd2, 5'd9, 16'($urandom) | 16'h8000));
			execute(iType(ops[i], 5'd3, 5'd10, 16'($urandom) & 16'h7fff));
		end
		execute(iType(opLui, 5'd0, 5'd11, 16'($urandom)));
	endtask

	task automatic shifts();
		loadReg(5'd12, $urandom);
		repeat (3) begin
			execute(rType(5'd0, 5'd1, 5'd13, 5'($urandom), fnSll));
			execute(rType(5'd0, 5'd1, 5'd14, 5'($urandom), fnSrl));
			execute(rType(5'd0, 5'd1, 5'd15, 5'($urandom), fnSra));
			execute(rType(5'd12, 5'd4, 5'd13, 5'd0, fnSllv));
			execute(rType(5'd12, 5'd4, 5'd14, 5'd0, fnSrlv));
			execute(rType(5'd12, 5'd4, 5'd15, 5'd0, fnSrav));
			loadReg(5'd12, $urandom);
		end
	endtask

	task automatic controlFlow();
		loadReg(5'd8, $urandom | 32'h8000_0000);
		loadReg(5'd9, ($urandom & 32'h7fff_ffff) | 32'd1);
		execute(iType(opBeq, 5'd9, 5'd9, 16'($urandom)));
		execute(iType(opBeq, 5'd8, 5'd9, 16'($urandom)));
		execute(iType(opBne, 5'd8, 5'd9, 16'($urandom)));
		execute(iType(opBne, 5'd9, 5'd9, 16'($urandom)));
		execute(iType(opBgtz, 5'd9, 5'd0, 16'($urandom)));
		execute(iType(opBgtz, 5'd8, 5'd0, 16'($urandom)));
		execute(iType(opBgtz, 5'd0, 5'd0, 16'($urandom)));
		execute(iType(opBlez, 5'd8, 5'd0, 16'($urandom)));
		execute(iType(opBlez, 5'd0, 5'd0, 16'($urandom)));
		execute(iType(opBlez, 5'd9, 5'd0, 16'($urandom)));
		execute(iType(opRegimm, 5'd8, 5'd0, 16'($urandom)));
		execute(iType(opRegimm, 5'd9, 5'd0, 16'($urandom)));
		execute(iType(opRegimm, 5'd9, 5'd1, 16'($urandom)));
		execute(iType(opRegimm, 5'd0, 5'd1, 16'($urandom)));
		execute(iType(opRegimm, 5'd8, 5'd1, 16'($urandom)));
		execute({opJ, 26'($urandom)});
		execute({opJal, 26'($urandom)});
		// Return address read back through the ALU
		execute(rType(5'd31, 5'd0, 5'd16, 5'd0, fnAddu));
		loadReg(5'd10, $urandom & 32'hffff_fffc);
		execute(rType(5'd10, 5'd0, 5'd0, 5'd0, fnJr));
	endtask

	task automatic zeroAndUnknown();
		execute(iType(opAddiu, 5'd1, 5'd0, 16'h0005));
		execute(rType(5'd1, 5'd2, 5'd0, 5'd0, fnOr));
		execute(rType(5'd0, 5'd0, 5'd17, 5'd0, fnAddu));
		execute({6'b111111, 26'($urandom)});
		execute(rType(5'd1, 5'd2, 5'd18, 5'd0, 6'b111111));
		execute(iType(opRegimm, 5'd1, 5'd5, 16'($urandom)));
		execute(iType(opAddiu, 5'd0, 5'd19, 16'($urandom)));
		idleCycle();
		idleCycle();
	endtask

	initial begin
		rst = 1'b1;
		instr = 32'd0;
		instrValid = 1'b0;
		seedDiscard = $urandom(32'h50fccd07);
		foreach (modelRegs[i]) modelRegs[i] = 32'd0;
		modelPc = ResetPc;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;

		resetState();
		registerAlu();
		immediateAlu();
		shifts();
		controlFlow();
		zeroAndUnknown();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/mipsCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module mipsCore import mipsPkg::*; #(
	parameter logic [31:0] ResetPc = 32'h0000_0000
) (
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic [31:0] instr,
	input  wire logic        instrValid,
	output logic      [31:0] pc,
	output logic             retValid,
	output retire_t          retire
);

	ctrl_t       ctrl;
	logic [31:0] rsData;
	logic [31:0] rtData;
	logic [31:0] aluResult;
	logic [31:0] pcPlus4;
	logic [4:0]  dstReg;
	logic [31:0] wrData;
	logic        wrEn;

	// Retire payload
	logic [31:0] retPc;
	logic        retWe;
	logic [4:0]  retDst;
	logic [31:0] retData;

	decoder decoder_inst (
		.instr (instr),
		.ctrl  (ctrl)
	);

	regFile regFile_inst (
		.clk    (clk),
		.rst    (rst),
		.rsAddr (instr[25:21]),
		.rtAddr (instr[20:16]),
		.wrAddr (dstReg),
		.wrEn   (wrEn),
		.wrData (wrData),
		.rsData (rsData),
		.rtData (rtData)
	);

	alu alu_inst (
		.instr  (instr),
		.ctrl   (ctrl),
		.rsData (rsData),
		.rtData (rtData),
		.result (aluResult)
	);

	nextPc #(.ResetPc(ResetPc)) nextPc_inst (
		.clk        (clk),
		.rst        (rst),
		.instrValid (instrValid),
		.instr      (instr),
		.ctrl       (ctrl),
		.rsData     (rsData),
		.rtData     (rtData),
		.pc         (pc),
		.pcPlus4    (pcPlus4)
	);

	//////////////////////////////////////////////////////////////////////
	// Writeback
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (ctrl.dst)
			dstRt:   dstReg = instr[20:16];
			dstR31:  dstReg = 5'd31;
			default: dstReg = instr[15:11];
		endcase
	end

	assign wrData = ctrl.link ? pcPlus4 : aluResult;
	assign wrEn   = instrValid && ctrl.regWe && (dstReg != 5'd0);

	always_ff @(posedge clk) begin
		if (rst) begin
			retValid <= 1'b0;
			retWe    <= 1'b0;
		end else begin
			retValid <= instrValid;
			retWe    <= wrEn;
		end
	end

	always_ff @(posedge clk) begin
		if (instrValid) begin
			retPc   <= pc;
			retDst  <= dstReg;
			retData <= wrData;
		end
	end

	// pc already holds the successor once the record is out
	assign retire = '{pc: retPc, regWe: retWe, dstReg: retDst, wrData: retData, nextPc: pc};

endmodule

`default_nettype wire

// ==== rtl/nextPc.sv ====
`timescale 1ns/1ns
`default_nettype none

module nextPc import mipsPkg::*; #(
	parameter logic [31:0] ResetPc = 32'h0000_0000
) (
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic        instrValid,
	input  wire logic [31:0] instr,
	input  ctrl_t            ctrl,
	input  wire logic [31:0] rsData,
	input  wire logic [31:0] rtData,
	output logic      [31:0] pc,
	output logic      [31:0] pcPlus4
);

	logic        taken;
	logic [31:0] branchTarget;
	logic [31:0] jumpTarget;
	logic [31:0] pcNext;

	assign pcPlus4 = pc + 32'd4;

	always_comb begin
		case (ctrl.cmp)
			cmpEq:   taken = (rsData == rtData);
			cmpNe:   taken = (rsData != rtData);
			cmpGtz:  taken = !rsData[31] && (rsData != 32'd0);
			cmpLez:  taken = rsData[31] || (rsData == 32'd0);
			cmpLtz:  taken = rsData[31];
			cmpGez:  taken = !rsData[31];
			default: taken = 1'b0;
		endcase
	end

	assign branchTarget = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
	assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00};

	always_comb begin
		case (ctrl.npc)
			npcBranch: pcNext = taken ? branchTarget : pcPlus4;
			npcJump:   pcNext = jumpTarget;
			npcReg:    pcNext = rsData;
			default:   pcNext = pcPlus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= ResetPc;
		end else if (instrValid) begin
			pc <= pcNext;
		end
	end

	pcWordAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu import mipsPkg::*; (
	input  wire logic [31:0] instr,
	input  ctrl_t            ctrl,
	input  wire logic [31:0] rsData,
	input  wire logic [31:0] rtData,
	output logic      [31:0] result
);

	logic [15:0] imm;
	logic [31:0] extImm;
	logic [31:0] opB;
	logic [4:0]  shamt;

	assign imm = instr[15:0];

	always_comb begin
		case (ctrl.ext)
			extZero:  extImm = {16'd0, imm};
			extUpper: extImm = {imm, 16'd0};
			default:  extImm = {{16{imm[15]}}, imm};
		endcase
	end

	assign opB   = ctrl.bFromImm ? extImm : rtData;
	assign shamt = ctrl.shiftByShamt ? instr[10:6] : rsData[4:0];

	//////////////////////////////////////////////////////////////////////
	// Operations
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (ctrl.aluOp)
			aluAdd:   result = rsData + opB;
			aluSub:   result = rsData - opB;
			aluAnd:   result = rsData & opB;
			aluOr:    result = rsData | opB;
			aluXor:   result = rsData ^ opB;
			aluNor:   result = ~(rsData | opB);
			aluSlt:   result = {31'd0, $signed(rsData) < $signed(opB)};
			aluSltu:  result = {31'd0, rsData < opB};
			// Shifts act on rt
			aluSll:   result = opB << shamt;
			aluSrl:   result = opB >> shamt;
			aluSra:   result = $unsigned($signed(opB) >>> shamt);
			aluPassB: result = opB;
			default:  result = 32'd0;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regFile (
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic [4:0]  rsAddr,
	input  wire logic [4:0]  rtAddr,
	input  wire logic [4:0]  wrAddr,
	input  wire logic        wrEn,
	input  wire logic [31:0] wrData,
	output logic      [31:0] rsData,
	output logic      [31:0] rtData
);

	// r0 has no storage
	logic [31:0] regs [31:1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wrEn && wrAddr != 5'd0) begin
			regs[wrAddr] <= wrData;
		end
	end

	assign rsData = (rsAddr == 5'd0) ? 32'd0 : regs[rsAddr];
	assign rtData = (rtAddr == 5'd0) ? 32'd0 : regs[rtAddr];

	// A write is visible to the next read
	writeReadsBack: assert property (
		@(posedge clk) disable iff (rst)
		$past(wrEn && !rst) && rsAddr == $past(wrAddr) && rsAddr != 5'd0
			|-> rsData == $past(wrData)
	);

endmodule

`default_nettype wire

// ==== rtl/decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module decoder import mipsPkg::*; (
	input  wire logic [31:0] instr,
	output ctrl_t            ctrl
);

	opcode_t op;
	funct_t  fn;

	assign op = opcode_t'(instr[31:26]);
	assign fn = funct_t'(instr[5:0]);

	always_comb begin
		// No-op unless an encoding below matches
		ctrl = '{
			aluOp:        aluAdd,
			bFromImm:     1'b0,
			shiftByShamt: 1'b0,
			ext:          extSign,
			cmp:          cmpEq,
			npc:          npcSeq,
			dst:          dstRd,
			regWe:        1'b0,
			link:         1'b0
		};

		case (op)
			opSpecial: begin
				case (fn)
					fnAddu: begin
						ctrl.regWe = 1'b1;
						ctrl.aluOp = aluAdd;
					end
					fnSubu: begin
						ctrl.regWe = 1'b1;
						ctrl.aluOp = aluSub;
					end
					fnAnd: begin
						ctrl.regWe = 1'b1;
						ctrl.aluOp = aluAnd;
					end
					fnOr: begin
						ctrl.regWe = 1'b1;
						ctrl.aluOp = aluOr;
					end
					fnXor: begin
						ctrl.regWe = 1'b1;
						ctrl.aluOp = aluXor;
					end
					fnNor: begin
						ctrl.regWe = 1'b1;
						ctrl.aluOp = aluNor;
					end
					fnSlt: begin
						ctrl.regWe = 1'b1;
						ctrl.aluOp = aluSlt;
					end
					fnSltu: begin
						ctrl.regWe = 1'b1;
						ctrl.aluOp = aluSltu;
					end
					fnSll, fnSrl, fnSra: begin
						ctrl.regWe        = 1'b1;
						ctrl.shiftByShamt = 1'b1;
						ctrl.aluOp        = (fn == fnSll) ? aluSll :
						                    (fn == fnSrl) ? aluSrl : aluSra;
					end
					fnSllv: begin
						ctrl.regWe = 1'b1;
						ctrl.aluOp = aluSll;
					end
					fnSrlv: begin
						ctrl.regWe = 1'b1;
						ctrl.aluOp = aluSrl;
					end
					fnSrav: begin
						ctrl.regWe = 1'b1;
						ctrl.aluOp = aluSra;
					end
					fnJr:   ctrl.npc = npcReg;
					default: ;
				endcase
			end

			// bltz and bgez live in the rt field
			opRegimm: begin
				case (instr[20:16])
					5'b00000: begin
						ctrl.npc = npcBranch;
						ctrl.cmp = cmpLtz;
					end
					5'b00001: begin
						ctrl.npc = npcBranch;
						ctrl.cmp = cmpGez;
					end
					default: ;
				endcase
			end

			opBeq: begin
				ctrl.npc = npcBranch;
				ctrl.cmp = cmpEq;
			end
			opBne: begin
				ctrl.npc = npcBranch;
				ctrl.cmp = cmpNe;
			end
			opBlez: begin
				ctrl.npc = npcBranch;
				ctrl.cmp = cmpLez;
			end
			opBgtz: begin
				ctrl.npc = npcBranch;
				ctrl.cmp = cmpGtz;
			end

			opJ: ctrl.npc = npcJump;
			opJal: begin
				ctrl.npc   = npcJump;
				ctrl.regWe = 1'b1;
				ctrl.dst   = dstR31;
				ctrl.link  = 1'b1;
			end

			opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
				ctrl.regWe    = 1'b1;
				ctrl.dst      = dstRt;
				ctrl.bFromImm = 1'b1;
				case (op)
					opSlti:  ctrl.aluOp = aluSlt;
					opSltiu: ctrl.aluOp = aluSltu;
					opAndi: begin
						ctrl.aluOp = aluAnd;
						ctrl.ext   = extZero;
					end
					opOri: begin
						ctrl.aluOp = aluOr;
						ctrl.ext   = extZero;
					end
					opXori: begin
						ctrl.aluOp = aluXor;
						ctrl.ext   = extZero;
					end
					opLui: begin
						ctrl.aluOp = aluPassB;
						ctrl.ext   = extUpper;
					end
					default: ctrl.aluOp = aluAdd;
				endcase
			end

			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

	//////////////////////////////////////////////////////////////////////
	// Instruction encodings
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [5:0] {
		opSpecial = 6'b000000,
		opRegimm  = 6'b000001,
		opJ       = 6'b000010,
		opJal     = 6'b000011,
		opBeq     = 6'b000100,
		opBne     = 6'b000101,
		opBlez    = 6'b000110,
		opBgtz    = 6'b000111,
		opAddiu   = 6'b001001,
		opSlti    = 6'b001010,
		opSltiu   = 6'b001011,
		opAndi    = 6'b001100,
		opOri     = 6'b001101,
		opXori    = 6'b001110,
		opLui     = 6'b001111
	} opcode_t;

	// SPECIAL function field
	typedef enum logic [5:0] {
		fnSll  = 6'b000000,
		fnSrl  = 6'b000010,
		fnSra  = 6'b000011,
		fnSllv = 6'b000100,
		fnSrlv = 6'b000110,
		fnSrav = 6'b000111,
		fnJr   = 6'b001000,
		fnAddu = 6'b100001,
		fnSubu = 6'b100011,
		fnAnd  = 6'b100100,
		fnOr   = 6'b100101,
		fnXor  = 6'b100110,
		fnNor  = 6'b100111,
		fnSlt  = 6'b101010,
		fnSltu = 6'b101011
	} funct_t;

	//////////////////////////////////////////////////////////////////////
	// Datapath control
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
		aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluPassB
	} aluOp_t;

	typedef enum logic [1:0] {extSign, extZero, extUpper} extOp_t;

	typedef enum logic [2:0] {cmpEq, cmpNe, cmpGtz, cmpLez, cmpLtz, cmpGez} cmpOp_t;

	typedef enum logic [1:0] {npcSeq, npcBranch, npcJump, npcReg} npcOp_t;

	typedef enum logic [1:0] {dstRd, dstRt, dstR31} dstSel_t;

	typedef struct packed {
		aluOp_t  aluOp;
		logic    bFromImm;
		logic    shiftByShamt;
		extOp_t  ext;
		cmpOp_t  cmp;
		npcOp_t  npc;
		dstSel_t dst;
		logic    regWe;
		// Write data is the return address
		logic    link;
	} ctrl_t;

	// One completed instruction
	typedef struct packed {
		logic [31:0] pc;
		logic        regWe;
		logic [4:0]  dstReg;
		logic [31:0] wrData;
		logic [31:0] nextPc;
	} retire_t;

endpackage

`default_nettype wire
